// ==== compile.f ====
hw/opl_pkg.sv
hw/beat_fifo.sv
hw/src_port_decode.sv
hw/dst_port_rewrite.sv
hw/packet_counters.sv
hw/output_port_lookup.sv
bench/tb_output_port_lookup.sv

// ==== Makefile ====
TOP = tb_output_port_lookup

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f compile.f
	obj_dir/V$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_output_port_lookup.sv ====
// Output port lookup testbench with packet table, scoreboard, back-pressure and watchdog
`default_nettype none

module tb_output_port_lookup
  import opl_pkg::*;
();

  localparam int fifo_depth_bits = 2;            // Depth 4 in the DUT
  localparam int n_rows = 14;

  // One table row describes one packet
  typedef struct packed {
    port_mask_t src;                             // One-hot source field
    logic [2:0] beats;                           // 1..4 beats
    port_mask_t orig_dst;                        // Destination as sent
    port_mask_t exp_dst;                         // Destination after crossover
  } pkt_row_t;

  pkt_row_t rows [n_rows] = '{
    '{8'b0000_0001, 3'd3, 8'h00, 8'b0000_0100},  // Eth 0 -> Eth 1
    '{8'b0000_0010, 3'd1, 8'h00, 8'b0000_0100},  // CPU 0 -> Eth 1
    '{8'b0000_0100, 3'd1, 8'h40, 8'b0000_0001},  // Eth 1 -> Eth 0
    '{8'b0000_1000, 3'd2, 8'h01, 8'b0000_0100},  // CPU 1 -> Eth 1
    '{8'b0001_0000, 3'd4, 8'h00, 8'b0100_0000},  // Eth 2 -> Eth 3
    '{8'b0010_0000, 3'd1, 8'hff, 8'b0000_0100},  // CPU 2 -> Eth 1
    '{8'b0100_0000, 3'd2, 8'h00, 8'b0001_0000},  // Eth 3 -> Eth 2
    '{8'b1000_0000, 3'd3, 8'h10, 8'b0000_0100},  // CPU 3 -> Eth 1
    '{8'b0000_0001, 3'd1, 8'h22, 8'b0000_0100},  // One-beat packets back to back
    '{8'b0000_0100, 3'd1, 8'h00, 8'b0000_0001},
    '{8'b0100_0000, 3'd1, 8'h04, 8'b0001_0000},
    '{8'b0000_0000, 3'd2, 8'h5a, 8'h5a},         // No source keeps the field
    '{8'b0101_0000, 3'd2, 8'h00, 8'b0001_0000},  // Eth 3 wins over Eth 2
    '{8'b0000_0011, 3'd1, 8'h00, 8'b0000_0100}   // CPU bit beats Eth bit
  };

  logic       AXI_ACLK;
  logic       AXI_RESETN;
  axis_beat_t s_axis;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  axis_beat_t m_axis;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  counter_t   forwarded_count;
  counter_t   cpu_count;

  axis_beat_t in_q [$];                          // Beats to send, in order
  axis_beat_t ref_q [$];                         // Matching expected output beats
  axis_beat_t exp_q [$];                         // Accepted, not yet seen at output
  logic [31:0] lcg_state = 32'he4a4;
  int          total_beats = 0;
  int          tx_idx = 0;
  int          rx_idx = 0;
  int          held_accepts = 0;
  logic        hold_ready = 1'b1;                // Output stalled at start

  output_port_lookup #(
    .fifo_depth_bits (fifo_depth_bits)
  ) dut (
    .AXI_ACLK        (AXI_ACLK),
    .AXI_RESETN      (AXI_RESETN),
    .s_axis          (s_axis),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .m_axis          (m_axis),
    .m_axis_tvalid   (m_axis_tvalid),
    .m_axis_tready   (m_axis_tready),
    .forwarded_count (forwarded_count),
    .cpu_count       (cpu_count)
  );

  initial begin
    AXI_ACLK = 1'b0;
    forever #10 AXI_ACLK = ~AXI_ACLK;            // Period 20
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input tdata_t got, input tdata_t exp);
    assert (got === exp) else begin
      $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Expands the table into input beats and expected output beats
  task automatic build_beats();
    axis_beat_t b;
    axis_beat_t e;
    for (int r = 0; r < n_rows; r++) begin
      for (int k = 0; k < int'(rows[r].beats); k++) begin
        for (int w = 0; w < data_w / 32; w++) begin
          b.tdata[32*w +: 32] = next_rand();
        end
        b.tstrb = tstrb_t'(next_rand());
        for (int w = 0; w < tuser_w / 32; w++) begin
          b.tuser[32*w +: 32] = next_rand();    // Random fields on body beats too
        end
        b.tlast = (k == int'(rows[r].beats) - 1);
        e = b;
        if (k == 0) begin
          b.tuser[src_port_pos +: 8] = rows[r].src;
          b.tuser[dst_port_pos +: 8] = rows[r].orig_dst;
          e = b;
          e.tuser[dst_port_pos +: 8] = rows[r].exp_dst;   // Only header rewritten
        end
        in_q.push_back(b);
        ref_q.push_back(e);
      end
    end
    total_beats = in_q.size();
  endtask

  function automatic int count_cpu_rows();
    int n;
    n = 0;
    for (int r = 0; r < n_rows; r++) begin
      if (|(rows[r].src & 8'b1010_1010)) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic compare_beat(input axis_beat_t e);
    check_value("m_axis.tdata", m_axis.tdata, e.tdata);
    check_value("m_axis.tstrb", tdata_t'(m_axis.tstrb), tdata_t'(e.tstrb));
    check_value("m_axis.tuser", tdata_t'(m_axis.tuser), tdata_t'(e.tuser));
    check_value("m_axis.tlast", tdata_t'(m_axis.tlast), tdata_t'(e.tlast));
  endtask

  // Sender holds valid until accepted and receiver stalls then toggles ready
  task automatic drive_inputs();
    logic [31:0] r;
    r = next_rand();
    if (tx_idx < total_beats) begin
      s_axis        = in_q[tx_idx];
      s_axis_tvalid = 1'b1;
    end else begin
      s_axis        = '0;
      s_axis_tvalid = 1'b0;
    end
    if (hold_ready) begin
      m_axis_tready = 1'b0;
    end else begin
      m_axis_tready = (r[18:16] > 3'd2);         // Ready about 5 of 8 cycles
    end
  endtask

  // Sampled mid-cycle before the handshakes complete at the next rising edge
  task automatic observe_cycle();
    logic       send_fire;
    logic       recv_fire;
    send_fire = s_axis_tvalid && s_axis_tready;
    recv_fire = m_axis_tvalid && m_axis_tready;
    // Fall-through gives valid one cycle after the first accept
    check_value("m_axis_tvalid", tdata_t'(m_axis_tvalid), tdata_t'(exp_q.size() != 0));
    if (m_axis_tvalid) begin
      compare_beat(exp_q[0]);                    // Also holds under back-pressure
    end
    if (hold_ready && !s_axis_tready) begin
      hold_ready = 1'b0;                         // Release output once FIFO is full enough
    end
    if (recv_fire) begin
      exp_q.delete(0);
      rx_idx++;
    end
    if (send_fire) begin
      exp_q.push_back(ref_q[tx_idx]);
      tx_idx++;
      if (hold_ready) begin
        held_accepts++;
        assert (held_accepts <= (1 << fifo_depth_bits) - 1) else begin
          $display("s_axis_tready stayed high after %0d beats with m_axis_tready low",
                   held_accepts);
          stop_on_error();
        end
      end
    end
  endtask

  initial begin
    AXI_RESETN    = 1'b0;
    s_axis        = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    build_beats();
    repeat (5) @(posedge AXI_ACLK);
    #1;
    AXI_RESETN = 1'b1;
    drive_inputs();
    @(negedge AXI_ACLK);
    check_value("m_axis_tvalid", tdata_t'(m_axis_tvalid), tdata_t'(1'b0));
    check_value("s_axis_tready", tdata_t'(s_axis_tready), tdata_t'(1'b1));
    while (rx_idx < total_beats) begin
      observe_cycle();
      @(posedge AXI_ACLK);
      #1;
      drive_inputs();
      @(negedge AXI_ACLK);
    end
    // Counters settled after the last header edge
    check_value("m_axis_tvalid", tdata_t'(m_axis_tvalid), tdata_t'(1'b0));
    check_value("forwarded_count", tdata_t'(forwarded_count), tdata_t'(n_rows));
    check_value("cpu_count", tdata_t'(cpu_count), tdata_t'(count_cpu_rows()));
    $display("Test passed");
    $finish;
  end

  // Watchdog allows 200 cycles per beat plus reset
  initial begin
    wait (total_beats > 0);
    repeat (200 * total_beats + 5) @(posedge AXI_ACLK);
    $display("Timeout: packets did not drain, %0d of %0d beats received",
             rx_idx, total_beats);
    stop_on_error();
  end

endmodule

`default_nettype wire

// ==== hw/output_port_lookup.sv ====
// Output port lookup top: input FIFO, header decode, port rewrite, counters
`default_nettype none

module output_port_lookup
  import opl_pkg::*;
#(
  parameter int fifo_depth_bits = 2              // Input FIFO depth, log2
) (
  input  wire logic  AXI_ACLK,
  input  wire logic  AXI_RESETN,
  input  axis_beat_t s_axis,                     // Incoming beat
  input  wire logic  s_axis_tvalid,
  output logic       s_axis_tready,
  output axis_beat_t m_axis,                     // Rewritten beat
  output logic       m_axis_tvalid,
  input  wire logic  m_axis_tready,
  output counter_t   forwarded_count,
  output counter_t   cpu_count
);

  axis_beat_t fifo_beat;                         // FIFO head
  logic       fifo_empty;
  logic       fifo_nearly_full;
  logic       fifo_valid;
  logic       fifo_wr_en;
  logic       beat_xfer;                         // Output handshake
  hdr_info_t  hdr;
  tuser_t     tuser_rw;                          // tuser after rewrite

  assign s_axis_tready = !fifo_nearly_full;      // Keep one slot spare
  assign fifo_wr_en    = s_axis_tvalid && s_axis_tready;
  assign fifo_valid    = !fifo_empty;
  assign beat_xfer     = fifo_valid && m_axis_tready;
  assign m_axis_tvalid = fifo_valid;

  beat_fifo #(
    .fifo_depth_bits (fifo_depth_bits)
  ) u_fifo (
    .AXI_ACLK    (AXI_ACLK),
    .AXI_RESETN  (AXI_RESETN),
    .wr_beat     (s_axis),
    .wr_en       (fifo_wr_en),
    .rd_en       (beat_xfer),
    .rd_beat     (fifo_beat),
    .empty       (fifo_empty),
    .nearly_full (fifo_nearly_full)
  );

  src_port_decode u_decode (
    .AXI_ACLK   (AXI_ACLK),
    .AXI_RESETN (AXI_RESETN),
    .tuser      (fifo_beat.tuser),
    .tlast      (fifo_beat.tlast),
    .beat_xfer  (beat_xfer),
    .hdr        (hdr)
  );

  dst_port_rewrite u_rewrite (
    .tuser_in  (fifo_beat.tuser),
    .hdr       (hdr),
    .tuser_out (tuser_rw)
  );

  packet_counters u_counters (
    .AXI_ACLK        (AXI_ACLK),
    .AXI_RESETN      (AXI_RESETN),
    .hdr             (hdr),
    .beat_xfer       (beat_xfer),
    .forwarded_count (forwarded_count),
    .cpu_count       (cpu_count)
  );

  // Payload, strobes and last flag straight from the head
  always_comb begin
    m_axis       = fifo_beat;
    m_axis.tuser = tuser_rw;                     // Only side-band changes
  end

endmodule

`default_nettype wire

// ==== hw/packet_counters.sv ====
// Forwarded and from-CPU packet counters, bumped on header transfer
`default_nettype none

module packet_counters
  import opl_pkg::*;
(
  input  wire logic  AXI_ACLK,
  input  wire logic  AXI_RESETN,
  input  hdr_info_t  hdr,                        // Decode of head beat
  input  wire logic  beat_xfer,                  // Head beat leaves this cycle
  output counter_t   forwarded_count,            // All packets passed
  output counter_t   cpu_count                   // Packets from CPU queues
);

  logic hdr_xfer;

  // One pulse per packet, on its header beat
  assign hdr_xfer = beat_xfer && hdr.is_header;

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      forwarded_count <= '0;
      cpu_count       <= '0;
    end else if (hdr_xfer) begin
      forwarded_count <= forwarded_count + counter_t'(1);   // Wraps
      if (hdr.from_cpu) begin
        cpu_count <= cpu_count + counter_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/dst_port_rewrite.sv ====
// Destination port rewrite in the side-band word for header beats
`default_nettype none

module dst_port_rewrite
  import opl_pkg::*;
(
  input  tuser_t     tuser_in,                   // Side-band from FIFO head
  input  hdr_info_t  hdr,                        // Decoder result
  output tuser_t     tuser_out                   // Side-band towards output
);

  port_mask_t new_dst;

  // Select destination for this header, no source bit keeps the field
  always_comb begin
    new_dst = tuser_in[dst_port_pos +: $bits(port_mask_t)];
    if (hdr.from_cpu) begin
      new_dst = cpu_dst;                         // CPU side always to Eth 1
    end else begin
      // Ascending scan so the highest set Ethernet bit wins
      for (int i = 0; i < 4; i++) begin
        if (hdr.src_mask[2*i]) begin
          new_dst = eth_dst_map[i];
        end
      end
    end
  end

  // Only header beats carry the routing field
  always_comb begin
    tuser_out = tuser_in;
    if (hdr.is_header) begin
      tuser_out[dst_port_pos +: $bits(port_mask_t)] = new_dst;
    end
  end

endmodule

`default_nettype wire

// ==== hw/src_port_decode.sv ====
// Packet header tracker and one-hot source port decoder on the FIFO head
`default_nettype none

module src_port_decode
  import opl_pkg::*;
(
  input  wire logic  AXI_ACLK,
  input  wire logic  AXI_RESETN,
  input  tuser_t     tuser,                      // Side-band of head beat
  input  wire logic  tlast,                      // Head beat ends packet
  input  wire logic  beat_xfer,                  // Head beat leaves this cycle
  output hdr_info_t  hdr                         // Decode for rewrite/counters
);

  pkt_state_t state;
  pkt_state_t state_next;
  port_mask_t src_field;
  port_mask_t cpu_bits;

  // Source field sits at a fixed offset in tuser
  assign src_field = tuser[src_port_pos +: $bits(port_mask_t)];

  // Odd bits mark the CPU queues
  assign cpu_bits = src_field & port_mask_t'(8'b1010_1010);

  // Combinational view of the head beat
  always_comb begin
    hdr.is_header = (state == st_header);
    hdr.from_cpu  = |cpu_bits;
    hdr.src_mask  = src_field;
  end

  // Moves only when a beat actually leaves
  always_comb begin
    state_next = state;
    case (state)
      st_header: begin
        if (beat_xfer && !tlast) begin
          state_next = st_in_packet;             // Multi-beat packet started
        end
      end
      st_in_packet: begin
        if (beat_xfer && tlast) begin
          state_next = st_header;                // Packet closed
        end
      end
      default: begin
        state_next = st_header;
      end
    endcase
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      state <= st_header;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/beat_fifo.sv ====
// Fall-through circular FIFO for stream beats with registered nearly-full flag
`default_nettype none

module beat_fifo
  import opl_pkg::*;
#(
  parameter int fifo_depth_bits = 2              // log2 of depth
) (
  input  wire logic       AXI_ACLK,
  input  wire logic       AXI_RESETN,
  input  axis_beat_t      wr_beat,               // Beat to store
  input  wire logic       wr_en,                 // Push, valid & ready
  input  wire logic       rd_en,                 // Pop head beat
  output axis_beat_t      rd_beat,               // Head beat, always visible
  output logic            empty,                 // No beat stored
  output logic            nearly_full            // At most one slot left
);

  localparam int depth = 1 << fifo_depth_bits;

  typedef logic [fifo_depth_bits-1:0] ptr_t;     // Wraps with the buffer
  typedef logic [fifo_depth_bits:0]   occ_t;     // 0..depth inclusive

  axis_beat_t mem [depth];                       // Beat storage, no reset

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  occ_t count;
  occ_t count_next;
  logic do_wr;
  logic do_rd;

  // Pop only with data present
  assign do_rd = rd_en && (count != '0);
  // Push only with room left
  assign do_wr = wr_en && (count != occ_t'(depth));

  // Head word falls through without a read latency
  assign rd_beat = mem[rd_ptr];
  assign empty   = (count == '0);

  always_comb begin
    count_next = count;
    case ({do_wr, do_rd})
      2'b10:   count_next = count + occ_t'(1);   // Push only
      2'b01:   count_next = count - occ_t'(1);   // Pop only
      default: count_next = count;               // Both or neither
    endcase
  end

  // Storage write
  always_ff @(posedge AXI_ACLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      nearly_full <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + ptr_t'(1);            // Natural wrap at depth
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      count       <= count_next;
      // Flag follows the occupancy it will have this cycle
      nearly_full <= (count_next >= occ_t'(depth - 1));
    end
  end

endmodule

`default_nettype wire

// ==== hw/opl_pkg.sv ====
// Stream widths, beat and header structs, port field types, crossover map, packet state enum
`default_nettype none

package opl_pkg;

  // Stream geometry
  localparam int data_w  = 256;                  // Beat payload width
  localparam int strb_w  = data_w / 8;           // One strobe per byte
  localparam int tuser_w = 128;                  // Side-band word width

  // Port fields inside tuser
  localparam int src_port_pos = 16;              // Source one-hot field
  localparam int dst_port_pos = 24;              // Destination one-hot field

  typedef logic [data_w-1:0]  tdata_t;
  typedef logic [strb_w-1:0]  tstrb_t;
  typedef logic [tuser_w-1:0] tuser_t;

  // Even bits are Ethernet ports 0..3, odd bits the matching CPU queues
  typedef logic [7:0] port_mask_t;

  typedef logic [31:0] counter_t;                // Wrapping statistics counter

  // One stream beat, last flag in the top bit
  typedef struct packed {
    logic   tlast;                               // Final beat of packet
    tuser_t tuser;                               // Side-band, carries port fields
    tstrb_t tstrb;                               // Byte enables
    tdata_t tdata;                               // Payload
  } axis_beat_t;

  // Decoder result for the beat at the FIFO head
  typedef struct packed {
    logic       is_header;                       // First beat of its packet
    logic       from_cpu;                        // Some odd source bit set
    port_mask_t src_mask;                        // Raw source field
  } hdr_info_t;

  // Crossover destinations, index is the Ethernet source port
  localparam port_mask_t [3:0] eth_dst_map = {
    port_mask_t'(8'b0001_0000),                  // Eth 3 -> Eth 2
    port_mask_t'(8'b0100_0000),                  // Eth 2 -> Eth 3
    port_mask_t'(8'b0000_0001),                  // Eth 1 -> Eth 0
    port_mask_t'(8'b0000_0100)                   // Eth 0 -> Eth 1
  };

  // All CPU traffic leaves on Ethernet port 1
  localparam port_mask_t cpu_dst = 8'b0000_0100;

  // Header tracking
  typedef enum logic {
    st_header,                                   // Next beat starts a packet
    st_in_packet                                 // Inside a multi-beat packet
  } pkt_state_t;

endpackage

`default_nettype wire
